/* design/core_pkg.sv */
/* Core package for the mini integer core
   Widths, RV32I opcode and funct encodings, instruction layouts and ALU ops */
package core_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Data and address width
  localparam int unsigned XLEN       = 32;
  // Register index width
  localparam int unsigned REG_ADDR_W = 5;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Major opcodes, register-register and register-immediate
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // Minor opcodes
  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;

  // Selects SUB over ADD in R-type
  localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

  ////////////////////////////////////////
  // Instruction layouts
  ////////////////////////////////////////

  // Register-register layout
  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } r_type_t;

  // Register-immediate layout, 12-bit signed immediate
  typedef struct packed {
    logic [11:0]           imm;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } i_type_t;

  // Same word, two views
  typedef union packed {
    r_type_t rtype;
    i_type_t itype;
  } instr_u;

  // ALU operation select
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

endpackage

/* design/fetch_unit.sv */
/* Instruction fetch unit
   Sequential PC, credit counter and request/grant memory port */
`timescale 1ns/1ps

module fetch_unit #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  logic                     fetch_enable_i,
  input  logic [core_pkg::XLEN-1:0] boot_addr_i,

  // Memory request side
  output logic                     instr_req_o,
  output logic [core_pkg::XLEN-1:0] instr_addr_o,
  input  logic                     instr_gnt_i,

  // One pulse per word popped from the buffer
  input  logic                     credit_i
);

  import core_pkg::*;

  // Counter must hold the value FIFO_DEPTH itself
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [CNT_W-1:0] CREDIT_MAX = CNT_W'(FIFO_DEPTH);

  logic [XLEN-1:0]  addr_q;
  logic [CNT_W-1:0] credit_q;
  logic             fetch_en_q;
  logic             req_pending_q;
  logic             req_accept;

  ////////////////////////////////////////
  // Request generation
  ////////////////////////////////////////

  // Registered enable, keeps req low on the first cycle out of reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fetch_en_q <= 1'b0;
    end else begin
      fetch_en_q <= fetch_enable_i;
    end
  end

  // Once raised, req holds until granted
  assign instr_req_o  = (fetch_en_q && (credit_q != '0)) || req_pending_q;
  assign instr_addr_o = addr_q;
  assign req_accept   = instr_req_o && instr_gnt_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_pending_q <= 1'b0;
    end else begin
      req_pending_q <= instr_req_o && !instr_gnt_i;
    end
  end

  // Next word address after every grant
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      addr_q <= boot_addr_i;
    end else if (req_accept) begin
      addr_q <= addr_q + XLEN'(4);
    end
  end

  ////////////////////////////////////////
  // Credit counter
  ////////////////////////////////////////

  // Take on grant, give back on pop; both at once cancel out
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_q <= CREDIT_MAX;
    end else begin
      case ({req_accept, credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // Waiting request keeps req and address steady
  a_req_stable : assert property (
    @(posedge clk_i) disable iff (reset_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o)
  );

  // Returned credits never exceed the buffer depth
  a_credit_max : assert property (
    @(posedge clk_i) disable iff (reset_i)
    credit_q <= CREDIT_MAX
  );

endmodule

/* design/instr_buffer.sv */
/* Instruction buffer
   Circular FIFO of fetched words, one credit back per pop */
`timescale 1ns/1ps

module instr_buffer #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                      clk_i,
  input  logic                      reset_i,

  // Memory response side
  input  logic                      push_i,
  input  logic [core_pkg::XLEN-1:0] push_data_i,

  // Execute side
  input  logic                      pop_i,
  output logic                      head_valid_o,
  output logic [core_pkg::XLEN-1:0] head_data_o,

  // Back to fetch
  output logic                      credit_o
);

  import core_pkg::*;

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

  logic [XLEN-1:0]  mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_pop;

  // Pop only counts with a word present
  assign do_pop       = pop_i && head_valid_o;
  assign head_valid_o = (count_q != '0);
  assign head_data_o  = mem_q[rd_ptr_q];
  assign credit_o     = do_pop;

  ////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Wrap explicitly, depth need not be a power of two
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == LAST_IDX) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_IDX) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage, word visible at head one cycle after push
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Credit scheme in fetch keeps the buffer from overflowing
  a_no_push_full : assert property (
    @(posedge clk_i) disable iff (reset_i)
    push_i |-> (count_q != FULL_CNT)
  );

  // Execute only pops a valid head
  a_no_pop_empty : assert property (
    @(posedge clk_i) disable iff (reset_i)
    pop_i |-> (count_q != '0)
  );

endmodule

/* design/register_file.sv */
/* Integer register file
   x1..x31 with two read ports and one write port, x0 hardwired to zero */
`timescale 1ns/1ps

module register_file (
  input  logic                            clk_i,
  input  logic                            reset_i,

  // Read ports
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [core_pkg::XLEN-1:0]       rdata_a_o,
  output logic [core_pkg::XLEN-1:0]       rdata_b_o,

  // Write port
  input  logic                            we_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [core_pkg::XLEN-1:0]       wdata_i
);

  import core_pkg::*;

  // Only the writable entries exist
  logic [XLEN-1:0] regs_q [31:1];

  // Writes to x0 are dropped
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational reads
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

  // Execute unit filters out x0 destinations before the write port
  a_no_x0_write : assert property (
    @(posedge clk_i) disable iff (reset_i)
    we_i |-> (waddr_i != '0)
  );

endmodule

/* design/exec_unit.sv */
/* Execute unit
   Decode, register read, ALU, write-back and the retire register */
`timescale 1ns/1ps

module exec_unit (
  input  logic                            clk_i,
  input  logic                            reset_i,

  input  logic [core_pkg::XLEN-1:0]       boot_addr_i,

  // Buffer head
  input  logic                            head_valid_i,
  input  core_pkg::instr_u                head_data_i,
  output logic                            pop_o,

  // Retire port
  output logic                            retire_valid_o,
  input  logic                            retire_ready_i,
  output logic [core_pkg::XLEN-1:0]       retire_pc_o,
  output logic [core_pkg::REG_ADDR_W-1:0] retire_rd_o,
  output logic                            retire_we_o,
  output logic [core_pkg::XLEN-1:0]       retire_wdata_o,
  output logic                            retire_illegal_o
);

  import core_pkg::*;

  logic [XLEN-1:0]       pc_q;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic [XLEN-1:0]       op_b;
  logic [XLEN-1:0]       alu_result;
  logic [REG_ADDR_W-1:0] rd;
  logic                  is_r_type;
  logic                  is_i_type;
  logic                  legal;
  logic                  rf_we;
  alu_op_e               alu_op;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  // Opcode, rd and rs1 share positions in both layouts
  assign is_r_type = (head_data_i.rtype.opcode == OPC_OP);
  assign is_i_type = (head_data_i.itype.opcode == OPC_OP_IMM);
  assign rd        = head_data_i.rtype.rd;

  always_comb begin
    alu_op = ALU_ADD;
    legal  = 1'b0;
    if (is_r_type) begin
      // funct7 picks SUB, anything else besides zero is unsupported
      unique case (head_data_i.rtype.funct3)
        FUNCT3_ADD_SUB: begin
          alu_op = (head_data_i.rtype.funct7 == FUNCT7_SUB) ? ALU_SUB : ALU_ADD;
          legal  = (head_data_i.rtype.funct7 == FUNCT7_SUB) ||
                   (head_data_i.rtype.funct7 == 7'b0);
        end
        FUNCT3_XOR: begin
          alu_op = ALU_XOR;
          legal  = (head_data_i.rtype.funct7 == 7'b0);
        end
        FUNCT3_OR: begin
          alu_op = ALU_OR;
          legal  = (head_data_i.rtype.funct7 == 7'b0);
        end
        FUNCT3_AND: begin
          alu_op = ALU_AND;
          legal  = (head_data_i.rtype.funct7 == 7'b0);
        end
        default: legal = 1'b0;
      endcase
    end else if (is_i_type) begin
      // Immediate forms, no SUBI in the ISA
      legal = 1'b1;
      unique case (head_data_i.itype.funct3)
        FUNCT3_ADD_SUB: alu_op = ALU_ADD;
        FUNCT3_XOR:     alu_op = ALU_XOR;
        FUNCT3_OR:      alu_op = ALU_OR;
        FUNCT3_AND:     alu_op = ALU_AND;
        default:        legal  = 1'b0;
      endcase
    end
  end

  ////////////////////////////////////////
  // Operands and ALU
  ////////////////////////////////////////

  register_file register_file_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .raddr_a_i (head_data_i.rtype.rs1),
    .raddr_b_i (head_data_i.rtype.rs2),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data),
    .we_i      (rf_we),
    .waddr_i   (rd),
    .wdata_i   (alu_result)
  );

  // Second operand, rs2 or sign-extended immediate
  assign op_b = is_r_type ? rs2_data
                          : {{(XLEN-12){head_data_i.itype.imm[11]}}, head_data_i.itype.imm};

  always_comb begin
    unique case (alu_op)
      ALU_SUB: alu_result = rs1_data - op_b;
      ALU_AND: alu_result = rs1_data & op_b;
      ALU_OR:  alu_result = rs1_data | op_b;
      ALU_XOR: alu_result = rs1_data ^ op_b;
      default: alu_result = rs1_data + op_b;
    endcase
  end

  ////////////////////////////////////////
  // Pop, write-back and retire
  ////////////////////////////////////////

  // Pop while the retire slot is free or draining this cycle
  assign pop_o = head_valid_i && (!retire_valid_o || retire_ready_i);
  // Lands on the pop edge, next pop sees it without forwarding
  assign rf_we = pop_o && legal && (rd != '0);

  // Own PC copy, fetch is strictly sequential
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q           <= boot_addr_i;
      retire_valid_o <= 1'b0;
    end else if (pop_o) begin
      pc_q           <= pc_q + XLEN'(4);
      retire_valid_o <= 1'b1;
    end else if (retire_ready_i) begin
      retire_valid_o <= 1'b0;
    end
  end

  // Retire payload
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      retire_pc_o      <= pc_q;
      retire_rd_o      <= rd;
      retire_we_o      <= legal && (rd != '0);
      retire_wdata_o   <= alu_result;
      retire_illegal_o <= !legal;
    end
  end

  // Stalled retire holds its item
  a_retire_hold : assert property (
    @(posedge clk_i) disable iff (reset_i)
    retire_valid_o && !retire_ready_i |=> retire_valid_o && $stable(retire_pc_o) &&
      $stable(retire_rd_o) && $stable(retire_we_o) && $stable(retire_wdata_o) &&
      $stable(retire_illegal_o)
  );

endmodule

/* design/mini_core.sv */
/* Mini core top level
   Fetch feeds the instruction buffer, execute drains it to the retire port */
`timescale 1ns/1ps

module mini_core #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                            clk_i,
  input  logic                            reset_i,

  input  logic                            fetch_enable_i,
  input  logic [core_pkg::XLEN-1:0]       boot_addr_i,

  // Instruction memory
  output logic                            instr_req_o,
  input  logic                            instr_gnt_i,
  output logic [core_pkg::XLEN-1:0]       instr_addr_o,
  input  logic                            instr_rvalid_i,
  input  logic [core_pkg::XLEN-1:0]       instr_rdata_i,

  // Retire
  output logic                            retire_valid_o,
  input  logic                            retire_ready_i,
  output logic [core_pkg::XLEN-1:0]       retire_pc_o,
  output logic [core_pkg::REG_ADDR_W-1:0] retire_rd_o,
  output logic                            retire_we_o,
  output logic [core_pkg::XLEN-1:0]       retire_wdata_o,
  output logic                            retire_illegal_o
);

  import core_pkg::*;

  // Buffer to fetch
  logic            credit;
  // Buffer to execute
  logic            head_valid;
  logic [XLEN-1:0] head_data;
  logic            pop;

  ////////////////////////////////////////
  // Fetch
  ////////////////////////////////////////

  fetch_unit #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fetch_unit_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .credit_i       (credit)
  );

  // Responses enter the buffer directly
  instr_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) instr_buffer_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .push_i       (instr_rvalid_i),
    .push_data_i  (instr_rdata_i),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_data_o  (head_data),
    .credit_o     (credit)
  );

  ////////////////////////////////////////
  // Execute
  ////////////////////////////////////////

  exec_unit exec_unit_inst (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .boot_addr_i      (boot_addr_i),
    .head_valid_i     (head_valid),
    .head_data_i      (head_data),
    .pop_o            (pop),
    .retire_valid_o   (retire_valid_o),
    .retire_ready_i   (retire_ready_i),
    .retire_pc_o      (retire_pc_o),
    .retire_rd_o      (retire_rd_o),
    .retire_we_o      (retire_we_o),
    .retire_wdata_o   (retire_wdata_o),
    .retire_illegal_o (retire_illegal_o)
  );

endmodule

/* verification/instr_mem_model.sv */
/* Instruction memory model
   Seeded 64-word program behind a request/grant port with random delays */
`timescale 1ns/1ps

module instr_mem_model #(
  parameter logic [31:0] SEED = 32'h0501d47b
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      instr_req_i,
  input  logic [core_pkg::XLEN-1:0] instr_addr_i,
  output logic                      instr_gnt_o,
  output logic                      instr_rvalid_o,
  output logic [core_pkg::XLEN-1:0] instr_rdata_o
);

  import core_pkg::*;

  logic [XLEN-1:0] prog [64];
  // Granted words in order, each with its remaining wait
  logic [XLEN-1:0] resp_data_q [$];
  int              resp_wait_q [$];
  integer          seed;
  logic            next_gnt;
  logic            next_rvalid;
  logic [XLEN-1:0] next_rdata;

  // Mostly legal ALU ops on x0..x7, some with an unused opcode
  task automatic build_program();
    instr_u w;
    int     kind;
    for (int i = 0; i < 64; i++) begin
      w    = instr_u'($random(seed));
      kind = {$random(seed)} % 10;
      w.rtype.rd  = REG_ADDR_W'({$random(seed)} % 8);
      w.rtype.rs1 = REG_ADDR_W'({$random(seed)} % 8);
      if (kind < 4) begin
        w.rtype.opcode = OPC_OP;
        w.rtype.rs2    = REG_ADDR_W'({$random(seed)} % 8);
        w.rtype.funct7 = 7'b0;
        case ({$random(seed)} % 5)
          0: w.rtype.funct3 = FUNCT3_ADD_SUB;
          1: begin
            w.rtype.funct3 = FUNCT3_ADD_SUB;
            w.rtype.funct7 = FUNCT7_SUB;
          end
          2: w.rtype.funct3 = FUNCT3_AND;
          3: w.rtype.funct3 = FUNCT3_OR;
          default: w.rtype.funct3 = FUNCT3_XOR;
        endcase
      end else if (kind < 9) begin
        // Immediate is random, so about half are negative
        w.itype.opcode = OPC_OP_IMM;
        case ({$random(seed)} % 4)
          0: w.itype.funct3 = FUNCT3_ADD_SUB;
          1: w.itype.funct3 = FUNCT3_AND;
          2: w.itype.funct3 = FUNCT3_OR;
          default: w.itype.funct3 = FUNCT3_XOR;
        endcase
      end else begin
        // custom-0 opcode, never decoded
        w.rtype.opcode = 7'b0001011;
      end
      prog[i] = w;
    end
  endtask

  ////////////////////////////////////////
  // Grant and response
  ////////////////////////////////////////

  initial begin
    seed = SEED;
    build_program();
    instr_gnt_o    = 1'b0;
    instr_rvalid_o = 1'b0;
    instr_rdata_o  = '0;
    forever begin
      // Port is stable at the falling edge
      @(negedge clk_i);
      next_gnt    = 1'b0;
      next_rvalid = 1'b0;
      next_rdata  = '0;
      if (reset_i) begin
        resp_data_q.delete();
        resp_wait_q.delete();
      end else begin
        if (instr_req_i && instr_gnt_o) begin
          resp_data_q.push_back(prog[instr_addr_i[7:2]]);
          resp_wait_q.push_back({$random(seed)} % 3);
        end
        // Oldest response first, at most one per cycle
        if (resp_wait_q.size() > 0) begin
          if (resp_wait_q[0] == 0) begin
            next_rvalid = 1'b1;
            next_rdata  = resp_data_q.pop_front();
            void'(resp_wait_q.pop_front());
          end else begin
            resp_wait_q[0] = resp_wait_q[0] - 1;
          end
        end
        next_gnt = ({$random(seed)} % 3) != 0;
      end
      @(posedge clk_i);
      #1;
      instr_gnt_o    = next_gnt;
      instr_rvalid_o = next_rvalid;
      instr_rdata_o  = next_rdata;
    end
  end

endmodule

/* verification/core_tb.sv */
/* Testbench for the mini core
   Random memory and retire stalls, golden register model and assertion checks */
`timescale 1ns/1ps

module core_tb;

  import core_pkg::*;

  localparam int          FIFO_DEPTH = 4;
  localparam logic [31:0] BOOT_ADDR  = 32'h0000_0080;
  localparam logic [31:0] SEED_INIT  = 32'h0501d47b;

  logic                  clk_i;
  logic                  reset_i;
  logic                  fetch_enable_i;
  logic [XLEN-1:0]       boot_addr_i;
  logic                  instr_req_o;
  logic                  instr_gnt_i;
  logic [XLEN-1:0]       instr_addr_o;
  logic                  instr_rvalid_i;
  logic [XLEN-1:0]       instr_rdata_i;
  logic                  retire_valid_o;
  logic                  retire_ready_i;
  logic [XLEN-1:0]       retire_pc_o;
  logic [REG_ADDR_W-1:0] retire_rd_o;
  logic                  retire_we_o;
  logic [XLEN-1:0]       retire_wdata_o;
  logic                  retire_illegal_o;

  // Golden state
  logic [XLEN-1:0]       gold_regs [32];
  logic [XLEN-1:0]       exp_pc;
  instr_u                cur_word;
  logic [XLEN:0]         gold_out;
  logic                  exp_legal;
  logic                  exp_we;
  logic [REG_ADDR_W-1:0] exp_rd;
  logic [XLEN-1:0]       exp_wdata;

  // Bookkeeping
  integer seed;
  logic   hold_ready_low = 1'b0;
  int     req_count;
  int     retire_count;
  int     ready_low_run;
  int     err_count = 0;
  int     err_base = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     cycles;

  mini_core #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) mini_core_inst (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fetch_enable_i   (fetch_enable_i),
    .boot_addr_i      (boot_addr_i),
    .instr_req_o      (instr_req_o),
    .instr_gnt_i      (instr_gnt_i),
    .instr_addr_o     (instr_addr_o),
    .instr_rvalid_i   (instr_rvalid_i),
    .instr_rdata_i    (instr_rdata_i),
    .retire_valid_o   (retire_valid_o),
    .retire_ready_i   (retire_ready_i),
    .retire_pc_o      (retire_pc_o),
    .retire_rd_o      (retire_rd_o),
    .retire_we_o      (retire_we_o),
    .retire_wdata_o   (retire_wdata_o),
    .retire_illegal_o (retire_illegal_o)
  );

  instr_mem_model #(
    .SEED (SEED_INIT)
  ) instr_mem_model_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_req_i    (instr_req_o),
    .instr_addr_i   (instr_addr_o),
    .instr_gnt_o    (instr_gnt_i),
    .instr_rvalid_o (instr_rvalid_i),
    .instr_rdata_o  (instr_rdata_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Retire ready, low about a third of the time unless held low
  initial begin
    seed           = SEED_INIT;
    retire_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      if (hold_ready_low) begin
        retire_ready_i = 1'b0;
      end else begin
        retire_ready_i = ({$random(seed)} % 3) != 0;
      end
    end
  end

  ////////////////////////////////////////
  // Golden model
  ////////////////////////////////////////

  // RV32I semantics, bit XLEN flags a legal word
  function automatic logic [XLEN:0] golden_exec(input instr_u w, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] res;
    logic            ok;
    imm = {{(XLEN-12){w.itype.imm[11]}}, w.itype.imm};
    res = '0;
    ok  = 1'b1;
    if (w.rtype.opcode == OPC_OP) begin
      case ({w.rtype.funct7, w.rtype.funct3})
        {7'b0, FUNCT3_ADD_SUB}:     res = a + b;
        {FUNCT7_SUB, FUNCT3_ADD_SUB}: res = a - b;
        {7'b0, FUNCT3_AND}:         res = a & b;
        {7'b0, FUNCT3_OR}:          res = a | b;
        {7'b0, FUNCT3_XOR}:         res = a ^ b;
        default:                    ok  = 1'b0;
      endcase
    end else if (w.itype.opcode == OPC_OP_IMM) begin
      case (w.itype.funct3)
        FUNCT3_ADD_SUB: res = a + imm;
        FUNCT3_AND:     res = a & imm;
        FUNCT3_OR:      res = a | imm;
        FUNCT3_XOR:     res = a ^ imm;
        default:        ok  = 1'b0;
      endcase
    end else begin
      ok = 1'b0;
    end
    return {ok, res};
  endfunction

  // Word the next retire should carry
  assign cur_word = instr_mem_model_inst.prog[exp_pc[7:2]];

  always_comb begin
    gold_out  = golden_exec(cur_word, gold_regs[cur_word.rtype.rs1],
                            gold_regs[cur_word.rtype.rs2]);
    exp_legal = gold_out[XLEN];
    exp_wdata = gold_out[XLEN-1:0];
    exp_rd    = cur_word.rtype.rd;
    exp_we    = exp_legal && (exp_rd != '0);
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < 32; i++) begin
        gold_regs[i] <= '0;
      end
      exp_pc        <= boot_addr_i;
      req_count     <= 0;
      retire_count  <= 0;
      ready_low_run <= 0;
    end else begin
      if (retire_valid_o && retire_ready_i) begin
        if (exp_we) begin
          gold_regs[exp_rd] <= exp_wdata;
        end
        exp_pc       <= exp_pc + 32'd4;
        retire_count <= retire_count + 1;
      end
      if (instr_req_o && instr_gnt_i) begin
        req_count <= req_count + 1;
      end
      ready_low_run <= retire_ready_i ? 0 : ready_low_run + 1;
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // Quiet during reset and the cycle after
  a_reset_quiet : assert property (@(posedge clk_i)
    $past(reset_i) |-> !instr_req_o && !retire_valid_o)
    else begin
      err_count++;
      $display("FAIL %0t: request or retire active around reset", $time);
    end

  // Fetch addresses follow the boot address in word steps
  a_fetch_addr : assert property (@(posedge clk_i) disable iff (reset_i)
    instr_req_o && instr_gnt_i |-> instr_addr_o == boot_addr_i + XLEN'(4 * req_count))
    else begin
      err_count++;
      $display("FAIL %0t: fetch address %h, expected %h", $time, $sampled(instr_addr_o),
               $sampled(boot_addr_i + XLEN'(4 * req_count)));
    end

  a_pc_order : assert property (@(posedge clk_i) disable iff (reset_i)
    retire_valid_o && retire_ready_i |-> retire_pc_o == exp_pc)
    else begin
      err_count++;
      $display("FAIL %0t: retire pc %h, expected %h", $time, $sampled(retire_pc_o),
               $sampled(exp_pc));
    end

  a_result : assert property (@(posedge clk_i) disable iff (reset_i)
    retire_valid_o && retire_ready_i && exp_we |-> retire_wdata_o == exp_wdata)
    else begin
      err_count++;
      $display("FAIL %0t: wdata %h, expected %h", $time, $sampled(retire_wdata_o),
               $sampled(exp_wdata));
    end

  // Illegal flag, write enable and rd against the golden decode
  a_flags : assert property (@(posedge clk_i) disable iff (reset_i)
    retire_valid_o && retire_ready_i |-> retire_illegal_o == !exp_legal &&
      retire_we_o == exp_we && retire_rd_o == exp_rd)
    else begin
      err_count++;
      $display("FAIL %0t: illegal/we/rd mismatch at pc %h", $time, $sampled(exp_pc));
    end

  // x0 destination never writes, golden x0 left at zero
  a_x0_no_write : assert property (@(posedge clk_i) disable iff (reset_i)
    retire_valid_o && retire_ready_i && retire_rd_o == '0 |-> !retire_we_o)
    else begin
      err_count++;
      $display("FAIL %0t: write enabled for x0 at pc %h", $time, $sampled(retire_pc_o));
    end

  a_retire_hold : assert property (@(posedge clk_i) disable iff (reset_i)
    retire_valid_o && !retire_ready_i |=> retire_valid_o && $stable(retire_pc_o) &&
      $stable(retire_rd_o) && $stable(retire_we_o) && $stable(retire_wdata_o) &&
      $stable(retire_illegal_o))
    else begin
      err_count++;
      $display("FAIL %0t: retire outputs changed while stalled", $time);
    end

  // Buffer depth plus the retire slot
  a_in_flight : assert property (@(posedge clk_i) disable iff (reset_i)
    (req_count - retire_count) <= FIFO_DEPTH + 1)
    else begin
      err_count++;
      $display("FAIL %0t: %0d items in flight", $time, $sampled(req_count - retire_count));
    end

  a_req_drops : assert property (@(posedge clk_i) disable iff (reset_i)
    ready_low_run >= 40 |-> !instr_req_o)
    else begin
      err_count++;
      $display("FAIL %0t: request still high after 40 stalled cycles", $time);
    end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  task automatic finish_test(input string name);
    tests_run++;
    if (err_count != err_base) begin
      tests_failed++;
    end
    $display("test %s finished with %0d errors", name, err_count - err_base);
    err_base = err_count;
  endtask

  task automatic wait_retires(input int count, input int max_cycles);
    int target;
    int waited;
    target = retire_count + count;
    waited = 0;
    while (retire_count < target && waited < max_cycles) begin
      @(negedge clk_i);
      waited++;
    end
    if (retire_count < target) begin
      err_count++;
      $display("Timed out after %0d cycles waiting for %0d retires", max_cycles, count);
    end
  endtask

  initial begin
    reset_i        = 1'b1;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    repeat (10) @(posedge clk_i);
    #1;
    reset_i        = 1'b0;
    fetch_enable_i = 1'b1;
    repeat (2) @(negedge clk_i);
    finish_test("reset");

    wait_retires(150, 2000);
    finish_test("random_traffic");

    // Stall retire, fetch must run out of credit
    @(negedge clk_i);
    hold_ready_low = 1'b1;
    cycles = 0;
    while (instr_req_o && cycles < 40) begin
      @(negedge clk_i);
      cycles++;
    end
    if (instr_req_o) begin
      err_count++;
      $display("instr_req_o stayed high through 40 cycles of retire back-pressure");
    end
    while (cycles < 44) begin
      @(negedge clk_i);
      cycles++;
    end
    hold_ready_low = 1'b0;
    wait_retires(30, 500);
    finish_test("back_pressure");

    $display("%0d tests run, %0d failed, %0d errors, %0d retired", tests_run, tests_failed,
             err_count, retire_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
design/core_pkg.sv
design/fetch_unit.sv
design/instr_buffer.sv
design/register_file.sv
design/exec_unit.sv
design/mini_core.sv
verification/instr_mem_model.sv
verification/core_tb.sv
